// ==== src/fetchCfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Halfwords delivered per fetch package
`define FETCH_HALFWORDS 8

// Offset width must cover FETCH_HALFWORDS slots
`define OFFS_BITS 3

// Byte address width of the fetch PC
`define ADDR_BITS 32

`endif

// ==== src/branchPkg.sv ====
`default_nettype none

`include "fetchCfg.svh"

package branchPkg;

    // One compressed instruction parcel
    typedef logic [15:0] halfword_t;

    // Halfword position inside a fetch package
    typedef logic [`OFFS_BITS-1:0] fetchOff_t;

    typedef logic [`ADDR_BITS-1:0] addr_t;

    // Kind of direct control transfer
    typedef enum logic {
        KIND_JUMP,
        KIND_BRANCH
    } brKind_e;

    // Decoded direct transfer at one instruction start
    typedef struct packed {
        logic      valid;
        brKind_e   kind;
        logic      compr;
        addr_t     target;
        fetchOff_t firstOffs;
        fetchOff_t finalOffs;
    } slotBranch_t;

endpackage

`default_nettype wire

// ==== src/slotViewIf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetchCfg.svh"

interface slotViewIf;
    import branchPkg::*;

    // Slot 0 is the carried halfword, slots 1 to 8 the current package
    halfword_t [`FETCH_HALFWORDS:0] halfwords;
    logic [`FETCH_HALFWORDS:0] is16;
    logic [`FETCH_HALFWORDS:0] is32;
    addr_t [`FETCH_HALFWORDS:0] slotAddr;

    // Address of the carried halfword
    addr_t carryAddr;

    modport scan(output halfwords, is16, is32, carryAddr);
    modport user(input halfwords, is16, is32);
    modport addrGen(input halfwords, carryAddr, output slotAddr);

endinterface

`default_nettype wire

// ==== src/boundaryScan.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetchCfg.svh"

module boundaryScan
    import branchPkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                clear,
    input  logic                                accept,
    input  addr_t                               fetchPc,
    input  fetchOff_t                           lastValid,
    input  halfword_t [`FETCH_HALFWORDS-1:0]    instrs,
    input  logic                                redirectTaken,
    slotViewIf.scan                             slotView
);

    halfword_t carryHw;
    addr_t carryAddr;
    logic carryFull;

    fetchOff_t fetchOffs;
    logic carryUsed;
    logic [`OFFS_BITS:0] lastIdx;

    logic [`FETCH_HALFWORDS:0] is16;
    logic [`FETCH_HALFWORDS:0] is32;

    assign fetchOffs = fetchPc[`OFFS_BITS:1];
    assign carryUsed = carryFull && (fetchOffs == '0);
    assign lastIdx = {1'b0, lastValid} + 1'b1;

    // Walk the slots in order, a 32-bit start swallows the following slot
    always_comb begin
        logic skip;
        skip = carryUsed;
        is16 = '0;
        is32 = '0;
        is32[0] = carryUsed;
        for (int i = 1; i <= `FETCH_HALFWORDS; i++) begin
            if ((i - 1) < int'(fetchOffs) || (i - 1) > int'(lastValid)) begin
                skip = 1'b0;
            end else if (skip) begin
                // Upper half of the previous instruction
                skip = 1'b0;
            end else if (instrs[i-1][1:0] == 2'b11) begin
                is32[i] = 1'b1;
                skip = 1'b1;
            end else begin
                is16[i] = 1'b1;
            end
        end
    end

    assign slotView.halfwords = {instrs, carryHw};
    assign slotView.is16 = is16;
    assign slotView.is32 = is32;
    assign slotView.carryAddr = carryAddr;

    // Keep a 32-bit instruction whose lower half closes the package
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            carryFull <= 1'b0;
        end else if (clear) begin
            carryFull <= 1'b0;
        end else if (accept) begin
            carryFull <= is32[lastIdx] && !redirectTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !clear) begin
            carryHw <= instrs[lastValid];
            carryAddr <= {fetchPc[`ADDR_BITS-1:`OFFS_BITS+1], lastValid, 1'b0};
        end
    end

    noDualMark: assert property (@(posedge clk) disable iff (rst)
        (is16 & is32) == '0);

    carryEmptyAfterClear: assert property (@(posedge clk) disable iff (rst)
        clear |=> !carryFull);

endmodule

`default_nettype wire

// ==== src/targetCalc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetchCfg.svh"

module targetCalc
    import branchPkg::*;
(
    input  addr_t           fetchPc,
    slotViewIf.addrGen      slotView,
    output addr_t           cjTarget [`FETCH_HALFWORDS:0],
    output addr_t           cbTarget [`FETCH_HALFWORDS:0],
    output addr_t           jTarget [`FETCH_HALFWORDS-1:0],
    output addr_t           bTarget [`FETCH_HALFWORDS-1:0]
);

    addr_t baseAddr;

    assign baseAddr = {fetchPc[`ADDR_BITS-1:`OFFS_BITS+1], {(`OFFS_BITS+1){1'b0}}};

    // Slot 0 lives in the previous package
    always_comb begin
        slotView.slotAddr[0] = slotView.carryAddr;
        for (int i = 1; i <= `FETCH_HALFWORDS; i++) begin
            slotView.slotAddr[i] = baseAddr + addr_t'(2 * (i - 1));
        end
    end

    // Compressed formats, one per halfword
    always_comb begin
        halfword_t h;
        for (int i = 0; i <= `FETCH_HALFWORDS; i++) begin
            h = slotView.halfwords[i];
            cjTarget[i] = slotView.slotAddr[i] + {{(`ADDR_BITS-12){h[12]}}, h[12], h[8],
                h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0};
            cbTarget[i] = slotView.slotAddr[i] + {{(`ADDR_BITS-9){h[12]}}, h[12], h[6:5],
                h[2], h[11:10], h[4:3], 1'b0};
        end
    end

    // Full-size formats use slot i and i+1
    always_comb begin
        logic [31:0] w;
        for (int i = 0; i < `FETCH_HALFWORDS; i++) begin
            w = {slotView.halfwords[i+1], slotView.halfwords[i]};
            jTarget[i] = slotView.slotAddr[i] + {{(`ADDR_BITS-20){w[31]}}, w[19:12], w[20],
                w[30:21], 1'b0};
            bTarget[i] = slotView.slotAddr[i] + {{(`ADDR_BITS-12){w[31]}}, w[7], w[30:25],
                w[11:8], 1'b0};
        end
    end

endmodule

`default_nettype wire

// ==== src/branchFinder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetchCfg.svh"

module branchFinder
    import branchPkg::*;
(
    slotViewIf.user     slotView,
    input  addr_t       cjTarget [`FETCH_HALFWORDS:0],
    input  addr_t       cbTarget [`FETCH_HALFWORDS:0],
    input  addr_t       jTarget [`FETCH_HALFWORDS-1:0],
    input  addr_t       bTarget [`FETCH_HALFWORDS-1:0],
    output slotBranch_t branches [`FETCH_HALFWORDS-1:0]
);

    // Quadrant 1 funct3 of the compressed transfers
    typedef enum logic [2:0] {
        C_JAL  = 3'b001,
        C_J    = 3'b101,
        C_BEQZ = 3'b110,
        C_BNEZ = 3'b111
    } cOp_e;

    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // Records are indexed by the offset of the final halfword
    always_comb begin
        halfword_t h;
        logic [31:0] w;
        fetchOff_t firstOffs;

        for (int i = 0; i < `FETCH_HALFWORDS; i++) begin
            branches[i] = '0;
        end

        for (int i = 0; i < `FETCH_HALFWORDS; i++) begin
            h = slotView.halfwords[i+1];
            if (slotView.is16[i+1] && h[1:0] == 2'b01) begin
                case (h[15:13])
                    C_J, C_JAL: begin
                        branches[i] = '{valid: 1'b1, kind: KIND_JUMP, compr: 1'b1,
                            target: cjTarget[i+1], firstOffs: fetchOff_t'(i),
                            finalOffs: fetchOff_t'(i)};
                    end
                    C_BEQZ, C_BNEZ: begin
                        branches[i] = '{valid: 1'b1, kind: KIND_BRANCH, compr: 1'b1,
                            target: cbTarget[i+1], firstOffs: fetchOff_t'(i),
                            finalOffs: fetchOff_t'(i)};
                    end
                    default: ;
                endcase
            end
        end

        // A start in view slot 0 is the carried instruction, reported at offset 0
        for (int i = 0; i < `FETCH_HALFWORDS; i++) begin
            w = {slotView.halfwords[i+1], slotView.halfwords[i]};
            firstOffs = fetchOff_t'((i == 0) ? 0 : i - 1);
            if (slotView.is32[i]) begin
                case (w[6:0])
                    OP_JAL: begin
                        branches[i] = '{valid: 1'b1, kind: KIND_JUMP, compr: 1'b0,
                            target: jTarget[i], firstOffs: firstOffs,
                            finalOffs: fetchOff_t'(i)};
                    end
                    OP_BRANCH: begin
                        // funct3 2 and 3 are not defined branches
                        if (w[14:12] != 3'd2 && w[14:12] != 3'd3) begin
                            branches[i] = '{valid: 1'b1, kind: KIND_BRANCH, compr: 1'b0,
                                target: bTarget[i], firstOffs: firstOffs,
                                finalOffs: fetchOff_t'(i)};
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/redirectGen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetchCfg.svh"

module redirectGen
    import branchPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,
    input  logic        accept,
    input  addr_t       fetchPc,
    input  fetchOff_t   lastValid,
    input  slotBranch_t branches [`FETCH_HALFWORDS-1:0],
    output logic        redirectValid,
    output fetchOff_t   redirectOffs,
    output addr_t       redirectDst,
    output logic        endOffsValid,
    output fetchOff_t   endOffs,
    output logic        btbUpdValid,
    output addr_t       btbUpdSrc,
    output addr_t       btbUpdDst,
    output brKind_e     btbUpdKind,
    output logic        btbUpdCompr
);

    fetchOff_t fetchOffs;
    logic jumpFound;
    logic xferFound;
    slotBranch_t jumpBr;
    slotBranch_t xferBr;

    assign fetchOffs = fetchPc[`OFFS_BITS:1];

    // Whole instruction must sit inside the valid window
    function automatic logic inRange(slotBranch_t br, fetchOff_t lo, fetchOff_t hi);
        return br.valid && br.firstOffs >= lo && br.finalOffs <= hi;
    endfunction

    // Lowest offset wins for both scans
    always_comb begin
        jumpFound = 1'b0;
        xferFound = 1'b0;
        jumpBr = '0;
        xferBr = '0;
        for (int i = 0; i < `FETCH_HALFWORDS; i++) begin
            if (inRange(branches[i], fetchOffs, lastValid)) begin
                if (!xferFound) begin
                    xferFound = 1'b1;
                    xferBr = branches[i];
                end
                if (!jumpFound && branches[i].kind == KIND_JUMP) begin
                    jumpFound = 1'b1;
                    jumpBr = branches[i];
                end
            end
        end
    end

    assign redirectValid = accept && jumpFound;
    assign redirectOffs = jumpBr.firstOffs;
    assign redirectDst = jumpBr.target;

    // Nothing after the jump is valid unless it ends the package
    assign endOffsValid = accept && jumpFound && (jumpBr.finalOffs != '1);
    assign endOffs = jumpBr.finalOffs + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btbUpdValid <= 1'b0;
        end else begin
            btbUpdValid <= accept && !clear && xferFound;
        end
    end

    // Source is the final halfword address
    always_ff @(posedge clk) begin
        if (accept && !clear && xferFound) begin
            btbUpdSrc <= {fetchPc[`ADDR_BITS-1:`OFFS_BITS+1], xferBr.finalOffs, 1'b0};
            btbUpdDst <= xferBr.target;
            btbUpdKind <= xferBr.kind;
            btbUpdCompr <= xferBr.compr;
        end
    end

    redirectNeedsAccept: assert property (@(posedge clk) disable iff (rst)
        redirectValid |-> accept);

endmodule

`default_nettype wire

// ==== src/fetchBranchDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetchCfg.svh"

module fetchBranchDecode (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        clear,
    input  logic                                        accept,
    input  branchPkg::addr_t                            fetchPc,
    input  branchPkg::fetchOff_t                        lastValid,
    input  branchPkg::halfword_t [`FETCH_HALFWORDS-1:0] instrs,
    output logic                                        redirectValid,
    output branchPkg::fetchOff_t                        redirectOffs,
    output branchPkg::addr_t                            redirectDst,
    output logic                                        endOffsValid,
    output branchPkg::fetchOff_t                        endOffs,
    output logic                                        btbUpdValid,
    output branchPkg::addr_t                            btbUpdSrc,
    output branchPkg::addr_t                            btbUpdDst,
    output branchPkg::brKind_e                          btbUpdKind,
    output logic                                        btbUpdCompr
);

    slotViewIf slotView();

    branchPkg::addr_t cjTarget [`FETCH_HALFWORDS:0];
    branchPkg::addr_t cbTarget [`FETCH_HALFWORDS:0];
    branchPkg::addr_t jTarget [`FETCH_HALFWORDS-1:0];
    branchPkg::addr_t bTarget [`FETCH_HALFWORDS-1:0];
    branchPkg::slotBranch_t branches [`FETCH_HALFWORDS-1:0];

    boundaryScan i_boundaryScan (
        .clk           (clk),
        .rst           (rst),
        .clear         (clear),
        .accept        (accept),
        .fetchPc       (fetchPc),
        .lastValid     (lastValid),
        .instrs        (instrs),
        .redirectTaken (redirectValid),
        .slotView      (slotView.scan)
    );

    targetCalc i_targetCalc (
        .fetchPc  (fetchPc),
        .slotView (slotView.addrGen),
        .cjTarget (cjTarget),
        .cbTarget (cbTarget),
        .jTarget  (jTarget),
        .bTarget  (bTarget)
    );

    branchFinder i_branchFinder (
        .slotView (slotView.user),
        .cjTarget (cjTarget),
        .cbTarget (cbTarget),
        .jTarget  (jTarget),
        .bTarget  (bTarget),
        .branches (branches)
    );

    redirectGen i_redirectGen (
        .clk           (clk),
        .rst           (rst),
        .clear         (clear),
        .accept        (accept),
        .fetchPc       (fetchPc),
        .lastValid     (lastValid),
        .branches      (branches),
        .redirectValid (redirectValid),
        .redirectOffs  (redirectOffs),
        .redirectDst   (redirectDst),
        .endOffsValid  (endOffsValid),
        .endOffs       (endOffs),
        .btbUpdValid   (btbUpdValid),
        .btbUpdSrc     (btbUpdSrc),
        .btbUpdDst     (btbUpdDst),
        .btbUpdKind    (btbUpdKind),
        .btbUpdCompr   (btbUpdCompr)
    );

endmodule

`default_nettype wire

// ==== tests/tbFetchBranchDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbFetchBranchDecode;

    localparam int TIMEOUT_CYCLES = 20;

    logic clk;
    logic rst;
    logic clear;
    logic accept;
    logic [31:0] fetchPc;
    logic [2:0] lastValid;
    logic [7:0][15:0] instrs;

    logic redirectValid;
    logic [2:0] redirectOffs;
    logic [31:0] redirectDst;
    logic endOffsValid;
    logic [2:0] endOffs;
    logic btbUpdValid;
    logic [31:0] btbUpdSrc;
    logic [31:0] btbUpdDst;
    logic btbUpdKind;
    logic btbUpdCompr;

    integer seed;
    int errors;
    int checks;

    // Package contents under construction, copied onto instrs when driven
    logic [7:0][15:0] pkg;
    logic [31:0] jal;

    fetchBranchDecode i_fetchBranchDecode (
        .clk           (clk),
        .rst           (rst),
        .clear         (clear),
        .accept        (accept),
        .fetchPc       (fetchPc),
        .lastValid     (lastValid),
        .instrs        (instrs),
        .redirectValid (redirectValid),
        .redirectOffs  (redirectOffs),
        .redirectDst   (redirectDst),
        .endOffsValid  (endOffsValid),
        .endOffs       (endOffs),
        .btbUpdValid   (btbUpdValid),
        .btbUpdSrc     (btbUpdSrc),
        .btbUpdDst     (btbUpdDst),
        .btbUpdKind    (btbUpdKind),
        .btbUpdCompr   (btbUpdCompr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // CJ format: imm[11|4|9:8|10|6|7|3:1|5]
    function automatic logic [15:0] compressedJump(input logic [2:0] funct3, input int imm);
        return {funct3, imm[11], imm[4], imm[9:8], imm[10], imm[6], imm[7], imm[3:1],
            imm[5], 2'b01};
    endfunction

    // CB format: imm[8|4:3] rs1' imm[7:6|2:1|5]
    function automatic logic [15:0] compressedBranch(input logic [2:0] funct3,
                                                     input logic [2:0] rs1, input int imm);
        return {funct3, imm[8], imm[4:3], rs1, imm[7:6], imm[2:1], imm[5], 2'b01};
    endfunction

    function automatic logic [31:0] jalWord(input logic [4:0] rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] branchWord(input logic [2:0] funct3, input int imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, funct3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // Quadrant 0, or quadrant 1 with a funct3 that is no transfer
    function automatic logic [15:0] randomFiller();
        logic [31:0] r;
        logic [2:0] funct3;
        r = $random(seed);
        case (r[17:16])
            2'd0: funct3 = 3'b000;
            2'd1: funct3 = 3'b010;
            2'd2: funct3 = 3'b011;
            default: funct3 = 3'b100;
        endcase
        return {funct3, r[12:2], 1'b0, r[18]};
    endfunction

    task automatic fillPackage();
        for (int i = 0; i < 8; i++) begin
            pkg[i] = randomFiller();
        end
    endtask

    task automatic drivePackage(input logic [31:0] pc, input logic [2:0] lv, input logic clr);
        @(posedge clk);
        accept <= 1'b1;
        clear <= clr;
        fetchPc <= pc;
        lastValid <= lv;
        instrs <= pkg;
        @(negedge clk);
    endtask

    // Package on the inputs but not accepted
    task automatic idleCycle(input logic [31:0] pc);
        @(posedge clk);
        accept <= 1'b0;
        clear <= 1'b0;
        fetchPc <= pc;
        lastValid <= 3'd7;
        instrs <= pkg;
        @(negedge clk);
    endtask

    task automatic reportMismatch(input string testName, input string field,
                                  input logic [31:0] expected, input logic [31:0] actual);
        errors++;
        $display("error in %s: %s expected %0h, actual %0h", testName, field, expected,
            actual);
    endtask

    task automatic expectRedirect(input string testName, input logic expValid,
                                  input logic [2:0] expOffs, input logic [31:0] expDst,
                                  input logic expEndValid, input logic [2:0] expEndOffs);
        checks++;
        if (redirectValid !== expValid) begin
            reportMismatch(testName, "redirectValid", 32'(expValid), 32'(redirectValid));
        end
        if (expValid && redirectOffs !== expOffs) begin
            reportMismatch(testName, "redirectOffs", 32'(expOffs), 32'(redirectOffs));
        end
        if (expValid && redirectDst !== expDst) begin
            reportMismatch(testName, "redirectDst", expDst, redirectDst);
        end
        if (endOffsValid !== expEndValid) begin
            reportMismatch(testName, "endOffsValid", 32'(expEndValid), 32'(endOffsValid));
        end
        if (expEndValid && endOffs !== expEndOffs) begin
            reportMismatch(testName, "endOffs", 32'(expEndOffs), 32'(endOffs));
        end
    endtask

    task automatic verifyBtbUpdate(input string testName, input logic expValid,
                                   input logic [31:0] expSrc, input logic [31:0] expDst,
                                   input logic expKind, input logic expCompr);
        checks++;
        if (btbUpdValid !== expValid) begin
            reportMismatch(testName, "btbUpdValid", 32'(expValid), 32'(btbUpdValid));
        end
        if (expValid && btbUpdSrc !== expSrc) begin
            reportMismatch(testName, "btbUpdSrc", expSrc, btbUpdSrc);
        end
        if (expValid && btbUpdDst !== expDst) begin
            reportMismatch(testName, "btbUpdDst", expDst, btbUpdDst);
        end
        if (expValid && btbUpdKind !== expKind) begin
            reportMismatch(testName, "btbUpdKind", 32'(expKind), 32'(btbUpdKind));
        end
        if (expValid && btbUpdCompr !== expCompr) begin
            reportMismatch(testName, "btbUpdCompr", 32'(expCompr), 32'(btbUpdCompr));
        end
    endtask

    task automatic waitIdle(input string testName);
        int cnt;
        cnt = 0;
        while ((btbUpdValid || redirectValid) && cnt < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cnt++;
        end
        if (btbUpdValid || redirectValid) begin
            errors++;
            $display("%s: outputs did not go idle within %0d cycles", testName,
                TIMEOUT_CYCLES);
        end
    endtask

    task automatic cjRedirect();
        fillPackage();
        pkg[2] = compressedJump(3'b101, 36);
        drivePackage(32'h0000_1000, 3'd7, 1'b0);
        // Slot 2 sits at 0x1004
        expectRedirect("c.j", 1'b1, 3'd2, 32'h1004 + 32'd36, 1'b1, 3'd3);
        idleCycle(32'h0000_1010);
        expectRedirect("c.j idle", 1'b0, 3'd0, 32'h0, 1'b0, 3'd0);
        verifyBtbUpdate("c.j", 1'b1, 32'h1004, 32'h1004 + 32'd36, branchPkg::KIND_JUMP, 1'b1);
        waitIdle("c.j");
    endtask

    task automatic spanningJal();
        jal = jalWord(5'd1, -256);
        fillPackage();
        pkg[7] = jal[15:0];
        drivePackage(32'h0000_2000, 3'd7, 1'b0);
        expectRedirect("jal lower half", 1'b0, 3'd0, 32'h0, 1'b0, 3'd0);
        fillPackage();
        pkg[0] = jal[31:16];
        drivePackage(32'h0000_2010, 3'd7, 1'b0);
        // The jal starts at the last slot of the previous package
        expectRedirect("jal upper half", 1'b1, 3'd0, 32'h200e - 32'd256, 1'b1, 3'd1);
        verifyBtbUpdate("jal lower half", 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
        idleCycle(32'h0000_2020);
        verifyBtbUpdate("jal upper half", 1'b1, 32'h2010, 32'h200e - 32'd256,
            branchPkg::KIND_JUMP, 1'b0);
        waitIdle("spanning jal");
    endtask

    task automatic validRange();
        fillPackage();
        pkg[1] = compressedJump(3'b101, 8);
        pkg[4] = compressedJump(3'b001, -64);
        pkg[7] = compressedJump(3'b101, 8);
        drivePackage(32'h0000_3006, 3'd6, 1'b0);
        expectRedirect("range inner c.jal", 1'b1, 3'd4, 32'h3008 - 32'd64, 1'b1, 3'd5);
        fillPackage();
        pkg[1] = compressedJump(3'b101, 8);
        pkg[6] = compressedJump(3'b101, 8);
        drivePackage(32'h0000_3014, 3'd4, 1'b0);
        expectRedirect("range outside", 1'b0, 3'd0, 32'h0, 1'b0, 3'd0);
        verifyBtbUpdate("range inner c.jal", 1'b1, 32'h3008, 32'h3008 - 32'd64,
            branchPkg::KIND_JUMP, 1'b1);
        idleCycle(32'h0000_3020);
        verifyBtbUpdate("range outside", 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
        waitIdle("valid range");
    endtask

    task automatic conditionalBranches();
        logic [31:0] br;
        fillPackage();
        br = branchWord(3'b000, 128);
        {pkg[2], pkg[1]} = br;
        pkg[4] = compressedBranch(3'b111, 3'd1, 16);
        drivePackage(32'h0000_4000, 3'd7, 1'b0);
        expectRedirect("beq and c.bnez", 1'b0, 3'd0, 32'h0, 1'b0, 3'd0);
        fillPackage();
        br = branchWord(3'd2, 64);
        {pkg[1], pkg[0]} = br;
        drivePackage(32'h0000_4010, 3'd7, 1'b0);
        expectRedirect("funct3 2", 1'b0, 3'd0, 32'h0, 1'b0, 3'd0);
        // The beq ends at slot 2 and starts at 0x4002
        verifyBtbUpdate("beq and c.bnez", 1'b1, 32'h4004, 32'h4002 + 32'd128,
            branchPkg::KIND_BRANCH, 1'b0);
        fillPackage();
        pkg[1] = compressedBranch(3'b110, 3'd2, -16);
        {pkg[4], pkg[3]} = jalWord(5'd0, 1024);
        drivePackage(32'h0000_4020, 3'd7, 1'b0);
        expectRedirect("branch then jal", 1'b1, 3'd3, 32'h4026 + 32'd1024, 1'b1, 3'd5);
        verifyBtbUpdate("funct3 2", 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
        idleCycle(32'h0000_4030);
        verifyBtbUpdate("branch then jal", 1'b1, 32'h4022, 32'h4022 - 32'd16,
            branchPkg::KIND_BRANCH, 1'b1);
        waitIdle("conditional branches");
    endtask

    task automatic clearAndAccept();
        jal = jalWord(5'd0, 32);
        fillPackage();
        pkg[2] = compressedBranch(3'b110, 3'd0, 32);
        pkg[7] = jal[15:0];
        drivePackage(32'h0000_5000, 3'd7, 1'b1);
        expectRedirect("clear with carry", 1'b0, 3'd0, 32'h0, 1'b0, 3'd0);
        // Upper half alone decodes as a quadrant 0 halfword
        fillPackage();
        pkg[0] = jal[31:16];
        drivePackage(32'h0000_5010, 3'd7, 1'b0);
        expectRedirect("after clear", 1'b0, 3'd0, 32'h0, 1'b0, 3'd0);
        verifyBtbUpdate("clear with carry", 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
        fillPackage();
        pkg[7] = jal[15:0];
        drivePackage(32'h0000_5020, 3'd7, 1'b0);
        verifyBtbUpdate("after clear", 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
        fillPackage();
        pkg[0] = compressedJump(3'b101, 8);
        idleCycle(32'h0000_5030);
        expectRedirect("accept low", 1'b0, 3'd0, 32'h0, 1'b0, 3'd0);
        verifyBtbUpdate("carry package", 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
        // Carry survives the cycle without accept
        fillPackage();
        pkg[0] = jal[31:16];
        drivePackage(32'h0000_5030, 3'd7, 1'b0);
        expectRedirect("carry held", 1'b1, 3'd0, 32'h502e + 32'd32, 1'b1, 3'd1);
        verifyBtbUpdate("accept low", 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
        idleCycle(32'h0000_5040);
        verifyBtbUpdate("carry held", 1'b1, 32'h5030, 32'h502e + 32'd32,
            branchPkg::KIND_JUMP, 1'b0);
        waitIdle("clear and accept");
    endtask

    initial begin
        seed = 32'hd718_09a3;
        errors = 0;
        checks = 0;
        pkg = '0;
        jal = '0;
        rst = 1'b1;
        clear = 1'b0;
        accept = 1'b0;
        fetchPc = '0;
        lastValid = '0;
        instrs = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        expectRedirect("reset", 1'b0, 3'd0, 32'h0, 1'b0, 3'd0);
        verifyBtbUpdate("reset", 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);

        cjRedirect();
        spanningJal();
        validRange();
        conditionalBranches();
        clearAndAccept();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+src
src/branchPkg.sv
src/slotViewIf.sv
src/boundaryScan.sv
src/targetCalc.sv
src/branchFinder.sv
src/redirectGen.sv
src/fetchBranchDecode.sv
tests/tbFetchBranchDecode.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch branch decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tbFetchBranchDecode
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VtbFetchBranchDecode)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
